// ==== include/dot_asserts.svh ====
// Dot product assertion macros
// Handshake stability and implication checks on clk, disabled during reset

`ifndef DOT_ASSERTS_SVH
`define DOT_ASSERTS_SVH

// Signal holds its value across a stalled handshake
// A cycle with valid high and ready low must be followed by an unchanged sig
`define DOT_ASSERT_STABLE(name, valid, ready, sig) \
  name : assert property ( \
    @(posedge clk) disable iff (!arst_n) \
    ((valid) && !(ready)) |=> $stable(sig) \
  );

// Same-cycle implication
`define DOT_ASSERT_IMPLIES(name, ante, cons) \
  name : assert property ( \
    @(posedge clk) disable iff (!arst_n) \
    (ante) |-> (cons) \
  );

`endif

// ==== source/dot_pkg.sv ====
// Dot product package
// Widths, lane coefficients and beat types shared by the fork, lanes and join

package dot_pkg;

  // ------------------------------------------------------------------------
  // Widths and lane count
  // ------------------------------------------------------------------------
  localparam int NUM_LANES = 4;
  localparam int SAMPLE_W  = 16;
  localparam int COEF_W    = 8;
  localparam int TAG_W     = 4;
  // Full product of one sample and one coefficient
  localparam int PROD_W    = SAMPLE_W + COEF_W;
  // Two extra bits hold the sum of four products
  localparam int SUM_W     = PROD_W + 2;

  typedef logic [SAMPLE_W-1:0]  sample_t;
  typedef logic [COEF_W-1:0]    coef_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [PROD_W-1:0]    prod_t;
  typedef logic [SUM_W-1:0]     sum_t;
  // One bit per lane
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // Fixed coefficient per lane
  // Highest set bit gives the lane latency of 2, 8, 5 and 8 cycles
  localparam coef_t LANE_COEFS [NUM_LANES] = '{8'h03, 8'h81, 8'h10, 8'hFF};

  // ------------------------------------------------------------------------
  // Beat types
  // ------------------------------------------------------------------------
  // Input beat, broadcast to every lane
  typedef struct packed {
    sample_t sample;
    tag_t    tag;
  } in_beat_t;

  // Result held by one lane
  typedef struct packed {
    prod_t prod;
    tag_t  tag;
  } lane_beat_t;

  // Joined output beat
  typedef struct packed {
    sum_t sum;
    tag_t tag;
  } out_beat_t;

  // Lane FSM states
  typedef enum logic [1:0] {
    IDLE,
    MUL,
    DONE
  } lane_state_t;

endpackage

// ==== source/flow_fork.sv ====
// Flow fork
// Broadcasts one ready-valid stream to every lane, no datapath

`timescale 1ns/100ps

`include "dot_asserts.svh"

module flow_fork (
  // Clock and reset drive only the checks
  input  logic                           clk,
  input  logic                           arst_n,

  // Upstream side
  input  logic                           in_valid,
  output logic                           in_ready,

  // Lane side
  // A lane valid may fall when another lane's ready falls
  input  logic [dot_pkg::NUM_LANES-1:0]  lane_ready,
  output logic [dot_pkg::NUM_LANES-1:0]  lane_valid
);

  import dot_pkg::*;

  // ------------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------------
  // Upstream transfers only when every lane takes the beat
  assign in_ready = &lane_ready;

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane_valid
    // Own ready is forced high so only the other lanes gate this valid
    // This avoids a loop from lane_ready[i] back to lane_valid[i]
    assign lane_valid[i] = in_valid && (&(lane_ready | (lane_mask_t'(1) << i)));
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  // Upstream keeps valid up until the beat is taken
  `DOT_ASSERT_STABLE(in_valid_stable_a, in_valid, in_ready, in_valid)

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane_checks
    // No lane sees a beat that upstream is not offering
    `DOT_ASSERT_IMPLIES(lane_valid_implies_in_a, lane_valid[i], in_valid)
  end

endmodule

// ==== source/mac_lane.sv ====
// Multiply lane
// Captures one beat and forms sample times a fixed coefficient by serial shift-add

`timescale 1ns/100ps

`include "dot_asserts.svh"

module mac_lane #(
  // Selects this lane's entry of the coefficient table
  parameter int LANE_IDX = 0
) (
  input  logic                clk,
  input  logic                arst_n,

  // Input beat from the fork
  input  logic                in_valid,
  output logic                in_ready,
  input  dot_pkg::in_beat_t   in_beat,

  // Product towards the join
  output logic                out_valid,
  input  logic                out_ready,
  output dot_pkg::lane_beat_t out_beat
);

  import dot_pkg::*;

  // ------------------------------------------------------------------------
  // State and datapath registers
  // ------------------------------------------------------------------------
  lane_state_t state;
  lane_state_t state_nxt;

  // Coefficient bits still to be consumed
  coef_t rem_coef;
  // Sample shifted left once per step
  prod_t mcand;
  // Running product
  prod_t acc;
  tag_t  tag_q;

  logic accept;
  logic last_step;

  // Only an idle lane takes a new beat
  assign in_ready  = (state == IDLE);
  assign accept    = in_valid && in_ready;

  // Last step when no set bits remain above bit 0
  assign last_step = (rem_coef[COEF_W-1:1] == '0);

  // ------------------------------------------------------------------------
  // Lane FSM
  // ------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: begin
        if (in_valid) begin
          state_nxt = MUL;
        end
      end
      MUL: begin
        // Early exit once the coefficient runs out of ones
        if (last_step) begin
          state_nxt = DONE;
        end
      end
      DONE: begin
        // Hold the product until the join takes it
        if (out_ready) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------------------------------------------------
  // Shift-add datapath
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      // Load coefficient and widened sample and clear the sum
      rem_coef <= LANE_COEFS[LANE_IDX];
      mcand    <= prod_t'(in_beat.sample);
      acc      <= '0;
      tag_q    <= in_beat.tag;
    end else if (state == MUL) begin
      // Add the shifted sample for each set coefficient bit
      if (rem_coef[0]) begin
        acc <= acc + mcand;
      end
      mcand    <= mcand << 1;
      rem_coef <= rem_coef >> 1;
    end
  end

  // Product is final in DONE
  assign out_valid     = (state == DONE);
  assign out_beat.prod = acc;
  assign out_beat.tag  = tag_q;

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  // Held result does not move while the join stalls
  `DOT_ASSERT_STABLE(out_beat_stable_a, out_valid, out_ready, out_beat)

endmodule

// ==== source/flow_join_sum.sv ====
// Join and sum
// Waits for every lane, adds the products and holds the result in one output slot

`timescale 1ns/100ps

`include "dot_asserts.svh"

module flow_join_sum (
  input  logic                          clk,
  input  logic                          arst_n,

  // Lane side
  input  logic [dot_pkg::NUM_LANES-1:0] lane_valid,
  // One ready shared by every lane
  output logic                          lane_ready,
  input  dot_pkg::lane_beat_t           lane_beats [dot_pkg::NUM_LANES],

  // Downstream side
  output logic                          out_valid,
  input  logic                          out_ready,
  output dot_pkg::out_beat_t            out_beat
);

  import dot_pkg::*;

  // ------------------------------------------------------------------------
  // Adder tree
  // ------------------------------------------------------------------------
  sum_t sum;
  logic tags_match;
  logic slot_free;

  // Products are widened first so the sum never overflows
  always_comb begin
    sum = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      sum = sum + sum_t'(lane_beats[i].prod);
    end
  end

  // All lanes should carry the same beat's tag
  always_comb begin
    tags_match = 1'b1;
    for (int i = 1; i < NUM_LANES; i++) begin
      if (lane_beats[i].tag != lane_beats[0].tag) begin
        tags_match = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Join handshake
  // ------------------------------------------------------------------------
  // Slot can take a new result when empty or emptying this cycle
  assign slot_free  = !out_valid || out_ready;

  // Release every lane at once so they stay in step
  assign lane_ready = (&lane_valid) && slot_free;

  // ------------------------------------------------------------------------
  // Output slot
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (lane_ready) begin
      // Load and drain in one cycle keeps valid up
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_ready) begin
      out_beat.sum <= sum;
      // Lane 0 speaks for the whole group
      out_beat.tag <= lane_beats[0].tag;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  // Lanes finishing together belong to the same input beat
  `DOT_ASSERT_IMPLIES(tags_agree_a, lane_ready, tags_match)

  // Stalled output holds its data
  `DOT_ASSERT_STABLE(out_beat_stable_a, out_valid, out_ready, out_beat)

endmodule

// ==== source/dot_product_top.sv ====
// Dot product top level
// Fork to four multiply lanes, then join and sum into one output stream

`timescale 1ns/100ps

module dot_product_top (
  input  logic               clk,
  input  logic               arst_n,

  // Input stream of samples and tags
  input  logic               in_valid,
  output logic               in_ready,
  input  dot_pkg::in_beat_t  in_beat,

  // Output stream of sums and tags
  output logic               out_valid,
  input  logic               out_ready,
  output dot_pkg::out_beat_t out_beat
);

  import dot_pkg::*;

  // ------------------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------------------
  // Fork to lanes
  lane_mask_t lane_in_valid;
  lane_mask_t lane_in_ready;

  // Lanes to join
  lane_mask_t lane_out_valid;
  logic       lane_out_ready;
  lane_beat_t lane_out [NUM_LANES];

  // Broadcast of the input handshake
  flow_fork u_fork (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .lane_ready (lane_in_ready),
    .lane_valid (lane_in_valid)
  );

  // One multiply lane per coefficient
  // in_beat is shared by all lanes
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lanes
    mac_lane #(
      .LANE_IDX (i)
    ) u_lane (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (lane_in_valid[i]),
      .in_ready  (lane_in_ready[i]),
      .in_beat   (in_beat),
      .out_valid (lane_out_valid[i]),
      .out_ready (lane_out_ready),
      .out_beat  (lane_out[i])
    );
  end

  // Join, sum and output slot
  flow_join_sum u_join (
    .clk        (clk),
    .arst_n     (arst_n),
    .lane_valid (lane_out_valid),
    .lane_ready (lane_out_ready),
    .lane_beats (lane_out),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

// ==== testbench/tb_vectors.svh ====
// Stimulus table for the dot product testbench
// One row per input beat, with the flow mode used to send it

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ----------------------------------------------------------------------------
// Row layout
// ----------------------------------------------------------------------------
// Columns: sample, tag, back-to-back send, random out_ready, test name
localparam int NAME_CHARS = 12;
localparam int NUM_VECS   = 24;

typedef struct packed {
  sample_t                 sample;
  tag_t                    tag;
  logic                    b2b;
  logic                    rnd;
  logic [8*NAME_CHARS-1:0] name;
} vec_row_t;

// ----------------------------------------------------------------------------
// Rows
// ----------------------------------------------------------------------------
// Basic rows drain fully, then back-to-back, then random stalls, then edges
localparam vec_row_t VECTORS [NUM_VECS] = '{
  '{16'h0005, 4'h0, 1'b0, 1'b0, "basic_0"},
  '{16'h1234, 4'h1, 1'b0, 1'b0, "basic_1"},
  '{16'h00FF, 4'h2, 1'b0, 1'b0, "basic_2"},
  '{16'h8000, 4'h3, 1'b0, 1'b0, "basic_3"},
  '{16'h7FFF, 4'h4, 1'b0, 1'b0, "basic_4"},
  '{16'h0A0A, 4'h5, 1'b0, 1'b0, "basic_5"},
  '{16'h4321, 4'h6, 1'b1, 1'b0, "b2b_0"},
  '{16'h0101, 4'h7, 1'b1, 1'b0, "b2b_1"},
  '{16'hBEEF, 4'h8, 1'b1, 1'b0, "b2b_2"},
  '{16'h2222, 4'h9, 1'b1, 1'b0, "b2b_3"},
  '{16'h5A5A, 4'hA, 1'b1, 1'b0, "b2b_4"},
  '{16'h0F0F, 4'hB, 1'b1, 1'b0, "b2b_5"},
  '{16'hCAFE, 4'hC, 1'b1, 1'b1, "stall_0"},
  '{16'h1357, 4'hD, 1'b1, 1'b1, "stall_1"},
  '{16'h2468, 4'hE, 1'b1, 1'b1, "stall_2"},
  '{16'h9999, 4'hF, 1'b1, 1'b1, "stall_3"},
  '{16'h7777, 4'h0, 1'b1, 1'b1, "stall_4"},
  '{16'hABCD, 4'h1, 1'b1, 1'b1, "stall_5"},
  '{16'h3141, 4'h2, 1'b1, 1'b1, "stall_6"},
  '{16'hFEDC, 4'h3, 1'b1, 1'b1, "stall_7"},
  '{16'h0000, 4'h4, 1'b0, 1'b0, "edge_zero"},
  '{16'h0001, 4'h5, 1'b0, 1'b0, "edge_one"},
  '{16'hFFFF, 4'h6, 1'b0, 1'b0, "edge_max"},
  '{16'hFFFE, 4'h7, 1'b0, 1'b0, "edge_max_m1"}
};

`endif

// ==== testbench/tb_dot_product.sv ====
// Dot product testbench
// Table-driven beats with random output stalls, checked against the dot product rule

`timescale 1ns/100ps

module tb_dot_product;

  import dot_pkg::*;

  `include "tb_vectors.svh"

  localparam int CLK_HALF        = 5;
  // Generous budget per row, covers stalls and draining
  localparam int WATCHDOG_CYCLES = NUM_VECS * 40;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  logic      in_ready;
  in_beat_t  in_beat;
  logic      out_valid;
  logic      out_ready;
  out_beat_t out_beat;

  // Expected results in input order
  sum_t exp_sum_q [$];
  tag_t exp_tag_q [$];
  int   exp_row_q [$];

  logic [31:0] rng_state;
  // High while the current phase stalls the output at random
  logic        rnd_ready;
  int          out_count;

  dot_product_top dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  always #CLK_HALF clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Sum over lanes of sample times coefficient
  function automatic sum_t dot_expected(input sample_t s);
    sum_t acc;
    acc = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      acc = acc + sum_t'(s) * sum_t'(LANE_COEFS[i]);
    end
    return acc;
  endfunction

  // Row name without the leading null bytes
  function automatic string row_name(input int idx);
    string      s;
    logic [7:0] ch;
    s = "";
    for (int b = NAME_CHARS - 1; b >= 0; b--) begin
      ch = VECTORS[idx].name[b*8 +: 8];
      if (ch != 8'h00) begin
        s = {s, string'(ch)};
      end
    end
    return s;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_sum(input string name, input sum_t exp, input sum_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: sum expected 0x%0h, actual 0x%0h", name, exp, act));
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: tag expected 0x%0h, actual 0x%0h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // --------------------------------------------------------------------------
  // Driver
  // --------------------------------------------------------------------------
  // Advance to just after the next rising edge and update out_ready
  task automatic step_cycle();
    @(posedge clk);
    #1;
    if (rnd_ready) begin
      rng_state = xorshift32(rng_state);
      // Ready about three cycles in four
      out_ready = (rng_state[1:0] != 2'b00);
    end else begin
      out_ready = 1'b1;
    end
  endtask

  // Offer one row and hold it until the fork takes it
  task automatic send_row(input int idx, input logic expect_busy);
    in_valid       = 1'b1;
    in_beat.sample = VECTORS[idx].sample;
    in_beat.tag    = VECTORS[idx].tag;
    @(negedge clk);
    // Lanes are still multiplying the previous beat
    if (expect_busy) begin
      check_flag({row_name(idx), " in_ready busy"}, 1'b0, in_ready);
    end
    while (!in_ready) begin
      step_cycle();
      @(negedge clk);
    end
    // Transfer happens on the coming edge
    exp_sum_q.push_back(dot_expected(VECTORS[idx].sample));
    exp_tag_q.push_back(VECTORS[idx].tag);
    exp_row_q.push_back(idx);
    step_cycle();
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_sum_q.size() != 0) begin
      step_cycle();
    end
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    rnd_ready = 1'b0;
    rng_state = 32'd55;
    out_count = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n    = 1'b1;
    out_ready = 1'b1;

    // Idle state straight out of reset
    @(negedge clk);
    check_flag("reset out_valid", 1'b0, out_valid);
    check_flag("reset in_ready", 1'b1, in_ready);
    step_cycle();

    for (int i = 0; i < NUM_VECS; i++) begin
      if (!VECTORS[i].b2b) begin
        wait_drained();
      end
      rnd_ready = VECTORS[i].rnd;
      send_row(i, VECTORS[i].b2b && (i > 0));
    end
    rnd_ready = 1'b0;
    wait_drained();

    // Quiet window, a stray output would hit an empty queue
    repeat (12) step_cycle();
    if (out_count == NUM_VECS && exp_sum_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure($sformatf("Got %0d outputs for %0d inputs", out_count, NUM_VECS));
    end
  end

  // --------------------------------------------------------------------------
  // Monitor
  // --------------------------------------------------------------------------
  // Samples at the falling edge where every signal has settled
  initial begin : monitor
    logic      stalled;
    out_beat_t held;
    int        row;
    stalled = 1'b0;
    held    = '0;
    forever begin
      @(negedge clk);
      if (arst_n) begin
        // Stalled beat must still be offered unchanged
        if (stalled) begin
          check_flag("stall out_valid held", 1'b1, out_valid);
          check_sum("stall sum held", held.sum, out_beat.sum);
          check_tag("stall tag held", held.tag, out_beat.tag);
        end
        stalled = 1'b0;
        if (out_valid && out_ready) begin
          if (exp_sum_q.size() == 0) begin
            report_failure("An output beat arrived with no input pending");
          end else begin
            row = exp_row_q.pop_front();
            check_sum(row_name(row), exp_sum_q.pop_front(), out_beat.sum);
            check_tag(row_name(row), exp_tag_q.pop_front(), out_beat.tag);
            out_count++;
          end
        end else if (out_valid) begin
          stalled = 1'b1;
          held    = out_beat;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------
  initial begin : watchdog
    #((WATCHDOG_CYCLES + 10) * 2 * CLK_HALF);
    report_failure("Watchdog expired because outputs stopped arriving");
  end

endmodule

// ==== files.f ====
+incdir+include
+incdir+testbench
source/dot_pkg.sv
source/flow_fork.sv
source/mac_lane.sv
source/flow_join_sum.sv
source/dot_product_top.sv
testbench/tb_dot_product.sv
